// ==== rtl/lb_defs.svh ====
// load balancer widths, port count and queue depths
`ifndef LB_DEFS_SVH
`define LB_DEFS_SVH

// memory bus word widths
`define LB_ADDR_W 48
`define LB_DATA_W 64

// requester ports, also the number of memory channels
`define LB_NPORTS 4

// sequence tag per port, wraps after LB_REQ_DEPTH requests
`define LB_SEQ_W 3

// request queue depth and in-flight limit per port
`define LB_REQ_DEPTH 8

// outstanding reads per channel, same as the post queue depth
`define LB_ISSUE_DEPTH 4

`endif

// ==== rtl/lb_bus_pkg.sv ====
// memory bus word types and the requester port mode encoding
package lb_bus_pkg;

`include "lb_defs.svh"

    // read address and read data words
    typedef logic [`LB_ADDR_W-1:0] addr_t;
    typedef logic [`LB_DATA_W-1:0] data_t;

    // which requester ports take part in scheduling
    typedef enum logic [1:0] {
        mode_all = 2'd0,
        mode_two = 2'd1,
        mode_one = 2'd2
    } port_mode_t;

endpackage

// ==== rtl/lb_tag_pkg.sv ====
// request bookkeeping types for port index, sequence tag and counters
package lb_tag_pkg;

`include "lb_defs.svh"

    typedef logic [$clog2(`LB_NPORTS)-1:0] port_idx_t;
    typedef logic [`LB_SEQ_W-1:0] seq_t;

    // served requests per queue, only used for comparison
    typedef logic [31:0] serve_cnt_t;

    // 0 to LB_ISSUE_DEPTH outstanding reads
    typedef logic [$clog2(`LB_ISSUE_DEPTH+1)-1:0] issue_cnt_t;

endpackage

// ==== rtl/lb_ifs.sv ====
// request queue and post queue handshake interfaces
`timescale 1ns/1ps

// queue head towards the scheduler
interface req_q_if;
    import lb_bus_pkg::*;
    import lb_tag_pkg::*;

    logic  empty;
    addr_t addr;
    seq_t  seq;
    logic  pop;

    modport source (output empty, output addr, output seq, input pop);
    modport sink (input empty, input addr, input seq, output pop);
endinterface

// tagged read response towards the reorder buffer
interface post_if;
    import lb_bus_pkg::*;
    import lb_tag_pkg::*;

    logic      empty;
    logic      full;
    port_idx_t port;
    seq_t      seq;
    data_t     data;
    logic      rd;

    modport source (output empty, output full, output port, output seq, output data, input rd);
    modport sink (input empty, input full, input port, input seq, input data, output rd);
endinterface

// ==== rtl/sync_fifo.sv ====
// show-ahead synchronous FIFO on a register array
`timescale 1ns/1ps

module sync_fifo #(
    parameter int width = 8,
    parameter int depth = 4
) (
    input  logic             clk,
    input  logic             rstn,
    input  logic             wr,
    input  logic [width-1:0] wdata,
    input  logic             rd,
    output logic [width-1:0] rdata,
    output logic             empty,
    output logic             full
);
    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    logic [width-1:0] mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             do_wr;
    logic             do_rd;

    function automatic logic [ptr_w-1:0] ptr_next(input logic [ptr_w-1:0] ptr);
        return (ptr == ptr_w'(depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // writes into a full FIFO and reads from an empty one are dropped
    assign do_wr = wr & ~full;
    assign do_rd = rd & ~empty;

    assign empty = (count == '0);
    assign full  = (count == cnt_w'(depth));

    // head always visible
    assign rdata = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (do_rd) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            count <= count + cnt_w'(do_wr) - cnt_w'(do_rd);
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wdata;
        end
    end

endmodule

// ==== rtl/req_queue.sv ====
// request queue that tags accepted reads and limits the reads in flight per port
`timescale 1ns/1ps
`include "lb_defs.svh"

module req_queue (
    input  logic              clk,
    input  logic              rstn,
    input  logic              arvalid,
    input  lb_bus_pkg::addr_t araddr,
    input  logic              ret_done,
    output logic              arready,
    req_q_if.source           q
);
    import lb_tag_pkg::*;

    localparam int entry_w = `LB_ADDR_W + `LB_SEQ_W;
    localparam int infl_w  = $clog2(`LB_REQ_DEPTH + 1);

    seq_t               seq_cnt;
    logic [infl_w-1:0]  inflight;
    logic               accept;
    logic               fifo_full;
    logic [entry_w-1:0] head;

    // in-flight limit keeps the 3-bit tags unique
    assign arready = ~fifo_full & (inflight != infl_w'(`LB_REQ_DEPTH));
    assign accept  = arvalid & arready;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            seq_cnt  <= '0;
            inflight <= '0;
        end else begin
            if (accept) begin
                seq_cnt <= seq_cnt + 1'b1;
            end
            inflight <= inflight + infl_w'(accept) - infl_w'(ret_done);
        end
    end

    // address and tag stored together
    sync_fifo #(
        .width (entry_w),
        .depth (`LB_REQ_DEPTH)
    ) fifo_i (
        .clk   (clk),
        .rstn  (rstn),
        .wr    (accept),
        .wdata ({araddr, seq_cnt}),
        .rd    (q.pop),
        .rdata (head),
        .empty (q.empty),
        .full  (fifo_full)
    );

    assign {q.addr, q.seq} = head;

endmodule

// ==== rtl/issue_scheduler.sv ====
// scheduler that picks the least served queue and the best memory channel
`timescale 1ns/1ps
`include "lb_defs.svh"

module issue_scheduler (
    input  logic                   clk,
    input  logic                   rstn,
    input  lb_bus_pkg::port_mode_t mode,
    req_q_if.sink                  q [`LB_NPORTS],
    input  logic [`LB_NPORTS-1:0]  chan_idle,
    input  logic [`LB_NPORTS-1:0]  chan_full,
    input  logic [`LB_NPORTS-1:0]  m_arready,
    output logic [`LB_NPORTS-1:0]  m_arvalid,
    output lb_bus_pkg::addr_t      m_araddr [`LB_NPORTS],
    output lb_tag_pkg::port_idx_t  iss_port,
    output lb_tag_pkg::seq_t       iss_seq
);
    import lb_bus_pkg::*;
    import lb_tag_pkg::*;

    localparam int nports = `LB_NPORTS;

    serve_cnt_t        served [nports];
    logic [nports-1:0] active;
    logic [nports-1:0] q_empty;
    addr_t             q_addr [nports];
    seq_t              q_seq [nports];
    logic [nports-1:0] pop;
    logic              port_found;
    port_idx_t         sel_port;
    serve_cnt_t        best_cnt;
    logic              chan_found;
    port_idx_t         sel_chan;
    logic              go;
    logic              fire;

    for (genvar i = 0; i < nports; i++) begin : g_q
        assign q_empty[i] = q[i].empty;
        assign q_addr[i]  = q[i].addr;
        assign q_seq[i]   = q[i].seq;
        assign q[i].pop   = pop[i];
    end

    always_comb begin
        case (mode)
            mode_all: active = '1;
            mode_two: active = nports'(3);
            default:  active = nports'(1);
        endcase
    end

    // least served among active non-empty queues, ties to lowest index
    always_comb begin
        port_found = 1'b0;
        sel_port   = '0;
        best_cnt   = '0;
        for (int i = 0; i < nports; i++) begin
            if (active[i] && !q_empty[i] && (!port_found || served[i] < best_cnt)) begin
                port_found = 1'b1;
                sel_port   = port_idx_t'(i);
                best_cnt   = served[i];
            end
        end
    end

    // idle channel wins over one that is merely not full
    always_comb begin
        chan_found = 1'b0;
        sel_chan   = '0;
        for (int c = nports - 1; c >= 0; c--) begin
            if (!chan_full[c]) begin
                chan_found = 1'b1;
                sel_chan   = port_idx_t'(c);
            end
        end
        for (int c = nports - 1; c >= 0; c--) begin
            if (chan_idle[c]) begin
                chan_found = 1'b1;
                sel_chan   = port_idx_t'(c);
            end
        end
    end

    assign go   = port_found & chan_found;
    assign fire = go & m_arready[sel_chan];

    always_comb begin
        for (int c = 0; c < nports; c++) begin
            m_arvalid[c] = go && (sel_chan == port_idx_t'(c));
            m_araddr[c]  = m_arvalid[c] ? q_addr[sel_port] : '0;
            pop[c]       = fire && (sel_port == port_idx_t'(c));
        end
    end

    assign iss_port = sel_port;
    assign iss_seq  = q_seq[sel_port];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < nports; i++) begin
                served[i] <= '0;
            end
        end else begin
            for (int i = 0; i < nports; i++) begin
                if (pop[i]) begin
                    served[i] <= served[i] + 1'b1;
                end
            end
        end
    end

endmodule

// ==== rtl/issue_unit.sv ====
// per-channel issue unit that pairs returned data with the oldest outstanding tag
`timescale 1ns/1ps
`include "lb_defs.svh"

module issue_unit (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  ar_fire,
    input  lb_tag_pkg::port_idx_t iss_port,
    input  lb_tag_pkg::seq_t      iss_seq,
    input  logic                  m_rvalid,
    input  lb_bus_pkg::data_t     m_rdata,
    output logic                  idle,
    output logic                  full,
    post_if.source                post
);
    import lb_tag_pkg::*;

    localparam int tag_w  = $bits(port_idx_t) + $bits(seq_t);
    localparam int post_w = tag_w + `LB_DATA_W;

    issue_cnt_t        outstanding;
    logic [tag_w-1:0]  oldest_tag;
    logic [post_w-1:0] post_head;
    logic              tag_empty;
    logic              resp_ok;
    logic              rd_fire;

    // channel returns in issue order, so the oldest tag owns the word
    assign resp_ok = m_rvalid & ~tag_empty;
    assign rd_fire = post.rd & ~post.empty;

    // an entry stays counted until the reorder buffer takes it
    always_ff @(posedge clk) begin
        if (!rstn) begin
            outstanding <= '0;
        end else begin
            outstanding <= outstanding + issue_cnt_t'(ar_fire) - issue_cnt_t'(rd_fire);
        end
    end

    assign idle = (outstanding == '0);
    assign full = (outstanding == issue_cnt_t'(`LB_ISSUE_DEPTH));

    sync_fifo #(
        .width (tag_w),
        .depth (`LB_ISSUE_DEPTH)
    ) tag_fifo_i (
        .clk   (clk),
        .rstn  (rstn),
        .wr    (ar_fire),
        .wdata ({iss_port, iss_seq}),
        .rd    (resp_ok),
        .rdata (oldest_tag),
        .empty (tag_empty),
        .full  ()
    );

    // never overflows, depth matches the outstanding limit
    sync_fifo #(
        .width (post_w),
        .depth (`LB_ISSUE_DEPTH)
    ) post_fifo_i (
        .clk   (clk),
        .rstn  (rstn),
        .wr    (resp_ok),
        .wdata ({oldest_tag, m_rdata}),
        .rd    (post.rd),
        .rdata (post_head),
        .empty (post.empty),
        .full  (post.full)
    );

    assign {post.port, post.seq, post.data} = post_head;

endmodule

// ==== rtl/reorder_buffer.sv ====
// reorder buffer that drains the post queues and returns data in request order
`timescale 1ns/1ps
`include "lb_defs.svh"

module reorder_buffer (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic [`LB_NPORTS-1:0] s_rready,
    post_if.sink                  post [`LB_NPORTS],
    output logic [`LB_NPORTS-1:0] s_rvalid,
    output lb_bus_pkg::data_t     s_rdata [`LB_NPORTS],
    output logic [`LB_NPORTS-1:0] ret_done
);
    import lb_bus_pkg::*;
    import lb_tag_pkg::*;

    localparam int nports = `LB_NPORTS;
    localparam int nslots = `LB_REQ_DEPTH;

    logic [nports-1:0] pq_empty;
    logic [nports-1:0] pq_full;
    logic [nports-1:0] pq_rd;
    port_idx_t         pq_port [nports];
    seq_t              pq_seq [nports];
    data_t             pq_data [nports];
    logic              drain;
    port_idx_t         drain_ch;
    data_t             slot_data [nports][nslots];
    logic [nslots-1:0] slot_valid [nports];
    seq_t              wb_ptr [nports];

    for (genvar i = 0; i < nports; i++) begin : g_post
        assign pq_empty[i] = post[i].empty;
        assign pq_full[i]  = post[i].full;
        assign pq_port[i]  = post[i].port;
        assign pq_seq[i]   = post[i].seq;
        assign pq_data[i]  = post[i].data;
        assign post[i].rd  = pq_rd[i];
    end

    // full queue first, otherwise lowest non-empty
    always_comb begin
        drain    = 1'b0;
        drain_ch = '0;
        for (int i = nports - 1; i >= 0; i--) begin
            if (!pq_empty[i]) begin
                drain    = 1'b1;
                drain_ch = port_idx_t'(i);
            end
        end
        for (int i = nports - 1; i >= 0; i--) begin
            if (pq_full[i]) begin
                drain_ch = port_idx_t'(i);
            end
        end
        for (int i = 0; i < nports; i++) begin
            pq_rd[i] = drain && (drain_ch == port_idx_t'(i));
        end
    end

    always_ff @(posedge clk) begin
        if (drain) begin
            slot_data[pq_port[drain_ch]][pq_seq[drain_ch]] <= pq_data[drain_ch];
        end
    end

    assign ret_done = s_rvalid & s_rready;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            s_rvalid <= '0;
            for (int p = 0; p < nports; p++) begin
                slot_valid[p] <= '0;
                wb_ptr[p]     <= '0;
            end
        end else begin
            for (int p = 0; p < nports; p++) begin
                if (ret_done[p]) begin
                    // retire the slot, next one goes out straight away if already here
                    slot_valid[p][wb_ptr[p]] <= 1'b0;
                    wb_ptr[p]                <= wb_ptr[p] + 1'b1;
                    s_rvalid[p]              <= slot_valid[p][seq_t'(wb_ptr[p] + 1'b1)];
                end else if (!s_rvalid[p]) begin
                    s_rvalid[p] <= slot_valid[p][wb_ptr[p]];
                end
                // drain never hits the slot being retired
                if (drain && pq_port[drain_ch] == port_idx_t'(p)) begin
                    slot_valid[p][pq_seq[drain_ch]] <= 1'b1;
                end
            end
        end
    end

    // slot cannot be rewritten while it is presented
    always_comb begin
        for (int p = 0; p < nports; p++) begin
            s_rdata[p] = slot_data[p][wb_ptr[p]];
        end
    end

endmodule

// ==== rtl/lb_top.sv ====
// read load balancer top with request queues, scheduler, issue units and reorder buffer
`timescale 1ns/1ps
`include "lb_defs.svh"

module lb_top (
    input  logic                   clk,
    input  logic                   rstn,
    input  lb_bus_pkg::port_mode_t mode,
    // requester side
    input  logic [`LB_NPORTS-1:0]  s_arvalid,
    input  lb_bus_pkg::addr_t      s_araddr [`LB_NPORTS],
    output logic [`LB_NPORTS-1:0]  s_arready,
    output logic [`LB_NPORTS-1:0]  s_rvalid,
    output lb_bus_pkg::data_t      s_rdata [`LB_NPORTS],
    input  logic [`LB_NPORTS-1:0]  s_rready,
    // memory channel side
    output logic [`LB_NPORTS-1:0]  m_arvalid,
    output lb_bus_pkg::addr_t      m_araddr [`LB_NPORTS],
    input  logic [`LB_NPORTS-1:0]  m_arready,
    input  logic [`LB_NPORTS-1:0]  m_rvalid,
    input  lb_bus_pkg::data_t      m_rdata [`LB_NPORTS]
);
    import lb_tag_pkg::*;

    logic [`LB_NPORTS-1:0] ret_done;
    logic [`LB_NPORTS-1:0] chan_idle;
    logic [`LB_NPORTS-1:0] chan_full;
    port_idx_t             iss_port;
    seq_t                  iss_seq;

    req_q_if rq [`LB_NPORTS] ();
    post_if  pq [`LB_NPORTS] ();

    for (genvar i = 0; i < `LB_NPORTS; i++) begin : g_port
        req_queue req_queue_i (
            .clk      (clk),
            .rstn     (rstn),
            .arvalid  (s_arvalid[i]),
            .araddr   (s_araddr[i]),
            .ret_done (ret_done[i]),
            .arready  (s_arready[i]),
            .q        (rq[i])
        );
    end

    issue_scheduler issue_scheduler_i (
        .clk       (clk),
        .rstn      (rstn),
        .mode      (mode),
        .q         (rq),
        .chan_idle (chan_idle),
        .chan_full (chan_full),
        .m_arready (m_arready),
        .m_arvalid (m_arvalid),
        .m_araddr  (m_araddr),
        .iss_port  (iss_port),
        .iss_seq   (iss_seq)
    );

    // tag recorded only by the channel that took the address
    for (genvar c = 0; c < `LB_NPORTS; c++) begin : g_chan
        issue_unit issue_unit_i (
            .clk      (clk),
            .rstn     (rstn),
            .ar_fire  (m_arvalid[c] & m_arready[c]),
            .iss_port (iss_port),
            .iss_seq  (iss_seq),
            .m_rvalid (m_rvalid[c]),
            .m_rdata  (m_rdata[c]),
            .idle     (chan_idle[c]),
            .full     (chan_full[c]),
            .post     (pq[c])
        );
    end

    reorder_buffer reorder_buffer_i (
        .clk      (clk),
        .rstn     (rstn),
        .s_rready (s_rready),
        .post     (pq),
        .s_rvalid (s_rvalid),
        .s_rdata  (s_rdata),
        .ret_done (ret_done)
    );

endmodule

// ==== verif/tb_lb_top.sv ====
// testbench for the read load balancer with memory channel models and directed tests
`timescale 1ns/1ps
`include "lb_defs.svh"

module tb_lb_top;
    import lb_bus_pkg::*;

    localparam int nports = `LB_NPORTS;
    // memory contents are the address xored with this pattern
    localparam data_t data_mask = 64'hc3a5_5a3c_0ff0_96e1;

    logic                 clk;
    logic                 rstn;
    port_mode_t           mode;
    logic [nports-1:0]    s_arvalid;
    addr_t                s_araddr [nports];
    logic [nports-1:0]    s_arready;
    logic [nports-1:0]    s_rvalid;
    data_t                s_rdata [nports];
    logic [nports-1:0]    s_rready;
    logic [nports-1:0]    m_arvalid;
    addr_t                m_araddr [nports];
    logic [nports-1:0]    m_arready;
    logic [nports-1:0]    m_rvalid;
    data_t                m_rdata [nports];

    logic [31:0]          lfsr = 32'h50ca393c;
    logic                 stall_en;
    logic [nports-1:0]    forbid;
    logic [nports-1:0]    held;
    data_t                held_data [nports];
    data_t                exp_q [nports][$];
    addr_t                chan_q [nports][$];
    int                   wait_cnt [nports];
    int                   sent_cnt [nports];
    int                   next_id [nports];
    int                   iss_chan;
    addr_t                iss_addr;
    int                   iss_count;

    lb_top dut_i (
        .clk       (clk),
        .rstn      (rstn),
        .mode      (mode),
        .s_arvalid (s_arvalid),
        .s_araddr  (s_araddr),
        .s_arready (s_arready),
        .s_rvalid  (s_rvalid),
        .s_rdata   (s_rdata),
        .s_rready  (s_rready),
        .m_arvalid (m_arvalid),
        .m_araddr  (m_araddr),
        .m_arready (m_arready),
        .m_rvalid  (m_rvalid),
        .m_rdata   (m_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // galois lfsr stepped once per bit taken
    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h80200003 : 32'h0);
            r    = {r[6:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic data_t mem_word(input addr_t a);
        return {16'h0000, a} ^ data_mask;
    endfunction

    // unique address per port and request number
    function automatic addr_t req_addr(input int p, input int n);
        return 48'h4000_0000_0000 | (48'(p) << 40) | (48'(n) << 3);
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped after a failure");
    endtask

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("ERR %0t %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    // scoreboard and issue monitor sampled at the rising edge
    always @(posedge clk) begin
        data_t exp_d;
        if (rstn) begin
            for (int p = 0; p < nports; p++) begin
                if (s_arvalid[p] && s_arready[p]) begin
                    exp_q[p].push_back(mem_word(s_araddr[p]));
                end
                if (forbid[p] && s_rvalid[p]) begin
                    abort_run($sformatf("response appeared on inactive port %0d", p));
                end
                if (held[p]) begin
                    if (!s_rvalid[p]) begin
                        abort_run($sformatf("s_rvalid on port %0d dropped before s_rready", p));
                    end
                    check($sformatf("s_rdata[%0d] held", p), s_rdata[p], held_data[p]);
                end
                if (s_rvalid[p] && s_rready[p]) begin
                    if (exp_q[p].size() == 0) begin
                        abort_run($sformatf("response on port %0d with nothing requested", p));
                    end else begin
                        exp_d = exp_q[p].pop_front();
                        check($sformatf("s_rdata[%0d]", p), s_rdata[p], exp_d);
                    end
                end
                held[p]      = s_rvalid[p] && !s_rready[p];
                held_data[p] = s_rdata[p];
            end
            for (int c = 0; c < nports; c++) begin
                if (m_arvalid[c] && m_arready[c]) begin
                    chan_q[c].push_back(m_araddr[c]);
                    iss_chan = c;
                    iss_addr = m_araddr[c];
                    iss_count++;
                end
            end
        end
    end

    // memory channels answer in order after a random delay of 0 to 7 cycles
    always @(negedge clk) begin
        for (int c = 0; c < nports; c++) begin
            if (m_rvalid[c]) begin
                void'(chan_q[c].pop_front());
                wait_cnt[c] = int'(rand_bits(3));
            end else if (chan_q[c].size() == 0) begin
                wait_cnt[c] = int'(rand_bits(3));
            end
            if (chan_q[c].size() != 0 && wait_cnt[c] == 0) begin
                m_rvalid[c] = 1'b1;
                m_rdata[c]  = mem_word(chan_q[c][0]);
            end else begin
                m_rvalid[c] = 1'b0;
                if (chan_q[c].size() != 0) begin
                    wait_cnt[c]--;
                end
            end
            m_arready[c] = stall_en ? (rand_bits(2) != 8'd0) : 1'b1;
        end
    end

    task automatic set_stalls(input logic on);
        @(posedge clk);
        stall_en = on;
    endtask

    // n requests per masked port while arready holds from falling to rising edge
    task automatic drive_reqs(input logic [3:0] mask, input int n, input int max_cycles,
                              input logic must_finish);
        logic [3:0] took;
        logic       pending;
        int         cycles;
        took   = '0;
        cycles = 0;
        for (int p = 0; p < nports; p++) begin
            sent_cnt[p] = 0;
        end
        forever begin
            @(negedge clk);
            pending = 1'b0;
            for (int p = 0; p < nports; p++) begin
                if (mask[p] && took[p]) begin
                    sent_cnt[p]++;
                    next_id[p]++;
                end
                if (mask[p] && sent_cnt[p] < n) begin
                    pending = 1'b1;
                end
            end
            if (!pending || cycles >= max_cycles) begin
                break;
            end
            for (int p = 0; p < nports; p++) begin
                if (mask[p]) begin
                    s_arvalid[p] = (sent_cnt[p] < n);
                    s_araddr[p]  = req_addr(p, next_id[p]);
                    took[p]      = s_arvalid[p] & s_arready[p];
                end
            end
            cycles++;
        end
        s_arvalid = s_arvalid & ~mask;
        if (pending && must_finish) begin
            abort_run("timeout: requester ports did not accept all requests");
        end
    endtask

    task automatic wait_drain(input logic [3:0] mask, input int max_cycles);
        logic busy;
        int   cycles;
        cycles = 0;
        forever begin
            busy = 1'b0;
            for (int p = 0; p < nports; p++) begin
                if (mask[p] && exp_q[p].size() != 0) begin
                    busy = 1'b1;
                end
            end
            if (!busy) begin
                break;
            end
            if (cycles >= max_cycles) begin
                abort_run("timeout: expected responses did not return");
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    task automatic single_read;
        addr_t a;
        int    issued;
        a      = req_addr(0, next_id[0]);
        issued = iss_count;
        drive_reqs(4'b0001, 1, 50, 1'b1);
        wait_drain(4'b0001, 100);
        check("issue count", 64'(iss_count - issued), 64'd1);
        check("issue channel", 64'(iss_chan), 64'd0);
        check("m_araddr", 64'(iss_addr), 64'(a));
    endtask

    task automatic reorder_traffic;
        set_stalls(1'b1);
        drive_reqs(4'b1111, 16, 2000, 1'b1);
        wait_drain(4'b1111, 4000);
    endtask

    task automatic one_port_mode;
        @(negedge clk);
        mode   = mode_one;
        forbid = 4'b1110;
        // port 1 fills up to the in-flight limit and stops
        drive_reqs(4'b0010, 12, 60, 1'b0);
        check("accepted on port 1", 64'(sent_cnt[1]), 64'd8);
        check("s_arready[1]", 64'(s_arready[1]), 64'd0);
        drive_reqs(4'b0001, 6, 500, 1'b1);
        wait_drain(4'b0001, 2000);
        @(negedge clk);
        mode   = mode_all;
        forbid = '0;
        wait_drain(4'b0010, 2000);
    endtask

    task automatic two_port_mode;
        @(negedge clk);
        mode   = mode_two;
        forbid = 4'b1100;
        drive_reqs(4'b1111, 3, 200, 1'b1);
        drive_reqs(4'b0011, 7, 500, 1'b1);
        wait_drain(4'b0011, 2000);
        @(negedge clk);
        mode   = mode_all;
        forbid = '0;
        wait_drain(4'b1100, 2000);
    endtask

    task automatic rready_backpressure;
        int cycles;
        @(negedge clk);
        s_rready[2] = 1'b0;
        drive_reqs(4'b0101, 6, 500, 1'b1);
        cycles = 0;
        while (!s_rvalid[2]) begin
            if (cycles >= 500) begin
                abort_run("timeout: port 2 never presented a response");
            end
            @(negedge clk);
            cycles++;
        end
        // port 0 keeps completing while port 2 is stalled
        wait_drain(4'b0001, 2000);
        // stalled returns keep port 2 at its in-flight limit
        drive_reqs(4'b0100, 4, 60, 1'b0);
        check("accepted on port 2", 64'(sent_cnt[2]), 64'd2);
        check("s_arready[2]", 64'(s_arready[2]), 64'd0);
        repeat (8) @(negedge clk);
        s_rready[2] = 1'b1;
        wait_drain(4'b0100, 2000);
    endtask

    initial begin
        rstn      = 1'b0;
        mode      = mode_all;
        s_arvalid = '0;
        s_rready  = '1;
        m_arready = '0;
        m_rvalid  = '0;
        stall_en  = 1'b0;
        forbid    = '0;
        held      = '0;
        iss_chan  = 0;
        iss_addr  = '0;
        iss_count = 0;
        for (int i = 0; i < nports; i++) begin
            s_araddr[i]  = '0;
            m_rdata[i]   = '0;
            held_data[i] = '0;
            wait_cnt[i]  = 0;
            sent_cnt[i]  = 0;
            next_id[i]   = 0;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;

        single_read();
        reorder_traffic();
        one_port_mode();
        two_port_mode();
        rready_backpressure();

        $display("TEST PASSED");
        $finish;
    end

    initial begin
        repeat (60000) @(posedge clk);
        abort_run("global timeout: the run did not finish");
    end

endmodule

// ==== sources.f ====
+incdir+rtl
rtl/lb_bus_pkg.sv
rtl/lb_tag_pkg.sv
rtl/lb_ifs.sv
rtl/sync_fifo.sv
rtl/req_queue.sv
rtl/issue_scheduler.sv
rtl/issue_unit.sv
rtl/reorder_buffer.sv
rtl/lb_top.sv
verif/tb_lb_top.sv

// ==== run.sh ====
#!/bin/sh
# builds the load balancer testbench with Verilator, runs it and scans the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_lb_top -f sources.f -o tb_lb_top \
    > build.log 2>&1 \
    || { cat build.log; echo "verilator build failed"; exit 1; }
./obj_dir/tb_lb_top > sim.log 2>&1
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1
grep -q "TEST PASSED" sim.log || exit 1
exit 0
